// ==== design/mem_sched_pkg.sv ====
/*
 * Memory scheduler package
 * Shared widths, descriptor and job configuration types, and the
 * quantization shift decode used by the bias path.
 */

package mem_sched_pkg;

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned ITER_W    = 16;
  localparam int unsigned MEM_DW    = 32;
  localparam int unsigned DATA_W    = 256;

  // Bytes from the first to the last memory word of one beat
  localparam int unsigned BEAT_JMP  = (MEM_DW / 8) * (DATA_W / MEM_DW - 1);

  // Full X read count per tile
  localparam int unsigned ARRAY_W   = 4;

  localparam int unsigned GIDX_W    = 8;
  localparam int unsigned ROW_IDX_W = 16;

  typedef logic [GIDX_W-1:0]    gidx_t;
  typedef logic [ROW_IDX_W-1:0] row_idx_t;

  typedef enum logic [1:0] {
    QINT8 = 2'd0,
    QINT4 = 2'd1,
    QINT2 = 2'd2
  } qmode_e;

  // Address generator descriptor, two dimensions
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] tot_len;
    logic [ADDR_W-1:0] d0_len;
    logic [ADDR_W-1:0] d0_stride;
    logic [ADDR_W-1:0] d1_len;
    logic [ADDR_W-1:0] d1_stride;
  } stream_desc_t;

  typedef struct packed {
    logic [ADDR_W-1:0] x_addr;
    logic [ADDR_W-1:0] w_addr;
    logic [ADDR_W-1:0] scales_addr;
    logic [ADDR_W-1:0] z_addr;
    logic [ITER_W-1:0] x_col_iters;
    logic [ITER_W-1:0] x_row_iters;
    logic [ITER_W-1:0] w_iters;
    logic [ITER_W-1:0] w_rows;
    logic [ADDR_W-1:0] x_rows_offs;
    logic [ADDR_W-1:0] x_d1_stride;
    logic [ADDR_W-1:0] w_d0_stride;
    logic [ADDR_W-1:0] w_tot_len;
    logic [ADDR_W-1:0] z_tot_len;
    logic [ADDR_W-1:0] z_d0_stride;
    logic [ITER_W-1:0] leftover_reads;
    logic [ITER_W-1:0] tot_x_reads;
    logic              dequant_en;
    qmode_e            qmode;
    logic              accumulate;
  } ms_cfg_t;

  // Narrower weights pack more elements per byte
  function automatic logic [1:0] quant_shift(qmode_e mode);
    logic [1:0] shift;
    case (mode)
      QINT2:   shift = 2'd3;
      QINT4:   shift = 2'd2;
      default: shift = 2'd1;
    endcase
    return shift;
  endfunction

endpackage : mem_sched_pkg

// ==== design/x_tile_walker.sv ====
/*
 * X tile walker
 * Nested column, W pass and row counters that step through the X
 * operand on each X stream completion, with the matching offsets
 * and the per-tile read count.
 */

module x_tile_walker
  import mem_sched_pkg::*;
#(
  parameter int unsigned ARRAY_W = mem_sched_pkg::ARRAY_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              x_done_i,
  input  ms_cfg_t           cfg_i,
  output logic [ADDR_W-1:0] x_offs_o,
  output logic [ITER_W-1:0] x_num_reads_o,
  output logic              x_reads_pending_o
);

  logic [ITER_W-1:0] col_q, wpass_q, row_q;
  logic [ITER_W-1:0] tot_reads_q;
  logic [ADDR_W-1:0] col_offs_q, row_offs_q;

  logic [ITER_W-1:0] col_max, wpass_max, row_max;
  logic              col_last, wpass_last, row_last;
  logic              wpass_step, row_step;

  assign col_max   = cfg_i.x_col_iters - 1'b1;
  assign wpass_max = cfg_i.w_iters - 1'b1;
  assign row_max   = cfg_i.x_row_iters - 1'b1;

  assign col_last   = col_q == col_max;
  assign wpass_last = wpass_q == wpass_max;
  assign row_last   = row_q == row_max;

  // Inner counters gate the outer ones
  assign wpass_step = x_done_i && col_last;
  assign row_step   = wpass_step && wpass_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q      <= '0;
      col_offs_q <= '0;
    end else if (clear_i) begin
      col_q      <= '0;
      col_offs_q <= '0;
    end else if (x_done_i) begin
      if (col_last) begin
        col_q      <= '0;
        col_offs_q <= '0;
      end else begin
        col_q      <= col_q + 1'b1;
        col_offs_q <= col_offs_q + ADDR_W'(BEAT_JMP);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wpass_q <= '0;
    end else if (clear_i) begin
      wpass_q <= '0;
    end else if (wpass_step) begin
      wpass_q <= wpass_last ? '0 : wpass_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q      <= '0;
      row_offs_q <= '0;
    end else if (clear_i) begin
      row_q      <= '0;
      row_offs_q <= '0;
    end else if (row_step) begin
      if (row_last) begin
        row_q      <= '0;
        row_offs_q <= '0;
      end else begin
        row_q      <= row_q + 1'b1;
        row_offs_q <= row_offs_q + cfg_i.x_rows_offs;
      end
    end
  end

  // Counts every completed X transfer of the job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tot_reads_q <= '0;
    end else if (clear_i) begin
      tot_reads_q <= '0;
    end else if (x_done_i) begin
      tot_reads_q <= tot_reads_q + 1'b1;
    end
  end

  assign x_offs_o = row_offs_q + col_offs_q;

  // Last row may be partial
  assign x_num_reads_o = (row_last && cfg_i.leftover_reads != '0) ? cfg_i.leftover_reads
                                                                  : ITER_W'(ARRAY_W);

  assign x_reads_pending_o = (tot_reads_q != '0) && (tot_reads_q != cfg_i.tot_x_reads);

endmodule : x_tile_walker

// ==== design/stream_desc_gen.sv ====
/*
 * Stream descriptor generator
 * Builds the X, W and Z address generator descriptors from the job
 * configuration and the walker state, and raises the start requests.
 */

module stream_desc_gen
  import mem_sched_pkg::*;
#(
  parameter int unsigned ARRAY_W = mem_sched_pkg::ARRAY_W
) (
  input  ms_cfg_t           cfg_i,
  input  logic [ADDR_W-1:0] x_offs_i,
  input  logic [ITER_W-1:0] x_num_reads_i,
  input  logic              x_reads_pending_i,
  input  logic              first_load_i,
  input  logic              x_ready_i,
  input  logic              w_ready_i,
  input  logic              y_ready_i,
  input  logic              z_ready_i,
  output stream_desc_t      x_desc_o,
  output stream_desc_t      w_desc_o,
  output stream_desc_t      z_desc_o,
  output logic              x_req_o,
  output logic              w_req_o,
  output logic              y_req_o,
  output logic              z_req_o
);

  // One column of the array per d1 step
  always_comb begin
    x_desc_o.base_addr = cfg_i.x_addr + x_offs_i;
    x_desc_o.tot_len   = ADDR_W'(x_num_reads_i);
    x_desc_o.d0_len    = ADDR_W'(1);
    x_desc_o.d0_stride = '0;
    x_desc_o.d1_len    = ADDR_W'(ARRAY_W);
    x_desc_o.d1_stride = cfg_i.x_d1_stride;
  end

  // In dequant mode the W stream fetches the scales array
  always_comb begin
    w_desc_o.tot_len   = cfg_i.w_tot_len;
    w_desc_o.d0_len    = ADDR_W'(cfg_i.w_rows);
    w_desc_o.d1_len    = ADDR_W'(cfg_i.w_iters);
    w_desc_o.d1_stride = ADDR_W'(BEAT_JMP);
    if (cfg_i.dequant_en) begin
      w_desc_o.base_addr = cfg_i.scales_addr;
      w_desc_o.d0_stride = '0;
    end else begin
      w_desc_o.base_addr = cfg_i.w_addr;
      w_desc_o.d0_stride = cfg_i.w_d0_stride;
    end
  end

  // Shared by the Z sink and the Y accumulate source
  always_comb begin
    z_desc_o.base_addr = cfg_i.z_addr;
    z_desc_o.tot_len   = cfg_i.z_tot_len;
    z_desc_o.d0_len    = ADDR_W'(ARRAY_W);
    z_desc_o.d0_stride = cfg_i.z_d0_stride;
    z_desc_o.d1_len    = ADDR_W'(cfg_i.w_iters);
    z_desc_o.d1_stride = ADDR_W'(BEAT_JMP);
  end

  // X keeps restarting until the whole operand has been read
  assign x_req_o = x_ready_i && (first_load_i || x_reads_pending_i);
  assign w_req_o = w_ready_i && first_load_i;
  assign y_req_o = y_ready_i && first_load_i && cfg_i.accumulate;
  assign z_req_o = z_ready_i && first_load_i;

endmodule : stream_desc_gen

// ==== design/bias_scaler.sv ====
/*
 * Bias scaler
 * Turns an index stream into byte offsets, one registered stage
 * with valid/ready on both sides.
 */

module bias_scaler
  import mem_sched_pkg::*;
#(
  parameter type idx_t       = gidx_t,
  parameter bit  APPLY_SHIFT = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic [ITER_W-1:0] stride_i,
  input  qmode_e            qmode_i,
  input  logic              valid_i,
  input  idx_t              data_i,
  output logic              ready_o,
  input  logic              ready_i,
  output logic              valid_o,
  output logic [ADDR_W-1:0] bias_o
);

  logic [ITER_W-1:0] stride_eff;
  logic [ADDR_W-1:0] product;
  logic              accept;
  logic              valid_q;
  logic [ADDR_W-1:0] bias_q;

  // Packed weights need a smaller stride
  assign stride_eff = APPLY_SHIFT ? (stride_i >> quant_shift(qmode_i)) : stride_i;
  assign product    = ADDR_W'(data_i) * ADDR_W'(stride_eff);

  assign ready_o = !valid_q || ready_i;
  assign accept  = valid_i && ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      bias_q <= product;
    end
  end

  assign valid_o = valid_q;
  assign bias_o  = bias_q;

endmodule : bias_scaler

// ==== design/mem_sched_top.sv ====
/*
 * Memory scheduler top
 * Packs the job configuration and connects the X tile walker, the
 * descriptor generator and the two bias scalers.
 */

module mem_sched_top
  import mem_sched_pkg::*;
#(
  parameter int unsigned ARRAY_W = mem_sched_pkg::ARRAY_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              first_load_i,
  input  logic              x_done_i,
  input  logic [ADDR_W-1:0] x_addr_i,
  input  logic [ADDR_W-1:0] w_addr_i,
  input  logic [ADDR_W-1:0] scales_addr_i,
  input  logic [ADDR_W-1:0] z_addr_i,
  input  logic [ITER_W-1:0] x_col_iters_i,
  input  logic [ITER_W-1:0] x_row_iters_i,
  input  logic [ITER_W-1:0] w_iters_i,
  input  logic [ITER_W-1:0] w_rows_i,
  input  logic [ADDR_W-1:0] x_rows_offs_i,
  input  logic [ADDR_W-1:0] x_d1_stride_i,
  input  logic [ADDR_W-1:0] w_d0_stride_i,
  input  logic [ADDR_W-1:0] w_tot_len_i,
  input  logic [ADDR_W-1:0] z_tot_len_i,
  input  logic [ADDR_W-1:0] z_d0_stride_i,
  input  logic [ITER_W-1:0] leftover_reads_i,
  input  logic [ITER_W-1:0] tot_x_reads_i,
  input  logic              dequant_en_i,
  input  logic [1:0]        qmode_i,
  input  logic              accumulate_i,
  input  logic              x_ready_i,
  input  logic              w_ready_i,
  input  logic              y_ready_i,
  input  logic              z_ready_i,
  output stream_desc_t      x_desc_o,
  output stream_desc_t      w_desc_o,
  output stream_desc_t      z_desc_o,
  output logic              x_req_o,
  output logic              w_req_o,
  output logic              y_req_o,
  output logic              z_req_o,
  input  logic              gidx_valid_i,
  input  gidx_t             gidx_data_i,
  output logic              gidx_ready_o,
  output logic              scales_bias_valid_o,
  output logic [ADDR_W-1:0] scales_bias_o,
  input  logic              scales_bias_ready_i,
  input  logic              row_valid_i,
  input  row_idx_t          row_data_i,
  output logic              row_ready_o,
  output logic              wq_bias_valid_o,
  output logic [ADDR_W-1:0] wq_bias_o,
  input  logic              wq_bias_ready_i
);

  ms_cfg_t           cfg;
  logic [ADDR_W-1:0] x_offs;
  logic [ITER_W-1:0] x_num_reads;
  logic              x_reads_pending;

  assign cfg.x_addr         = x_addr_i;
  assign cfg.w_addr         = w_addr_i;
  assign cfg.scales_addr    = scales_addr_i;
  assign cfg.z_addr         = z_addr_i;
  assign cfg.x_col_iters    = x_col_iters_i;
  assign cfg.x_row_iters    = x_row_iters_i;
  assign cfg.w_iters        = w_iters_i;
  assign cfg.w_rows         = w_rows_i;
  assign cfg.x_rows_offs    = x_rows_offs_i;
  assign cfg.x_d1_stride    = x_d1_stride_i;
  assign cfg.w_d0_stride    = w_d0_stride_i;
  assign cfg.w_tot_len      = w_tot_len_i;
  assign cfg.z_tot_len      = z_tot_len_i;
  assign cfg.z_d0_stride    = z_d0_stride_i;
  assign cfg.leftover_reads = leftover_reads_i;
  assign cfg.tot_x_reads    = tot_x_reads_i;
  assign cfg.dequant_en     = dequant_en_i;
  assign cfg.qmode          = qmode_e'(qmode_i);
  assign cfg.accumulate     = accumulate_i;

  x_tile_walker #(
    .ARRAY_W (ARRAY_W)
  ) u_walker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clear_i           (clear_i),
    .x_done_i          (x_done_i),
    .cfg_i             (cfg),
    .x_offs_o          (x_offs),
    .x_num_reads_o     (x_num_reads),
    .x_reads_pending_o (x_reads_pending)
  );

  stream_desc_gen #(
    .ARRAY_W (ARRAY_W)
  ) u_desc_gen (
    .cfg_i             (cfg),
    .x_offs_i          (x_offs),
    .x_num_reads_i     (x_num_reads),
    .x_reads_pending_i (x_reads_pending),
    .first_load_i      (first_load_i),
    .x_ready_i         (x_ready_i),
    .w_ready_i         (w_ready_i),
    .y_ready_i         (y_ready_i),
    .z_ready_i         (z_ready_i),
    .x_desc_o          (x_desc_o),
    .w_desc_o          (w_desc_o),
    .z_desc_o          (z_desc_o),
    .x_req_o           (x_req_o),
    .w_req_o           (w_req_o),
    .y_req_o           (y_req_o),
    .z_req_o           (z_req_o)
  );

  // Scales are not packed, so the group index uses the full stride
  bias_scaler #(
    .idx_t       (gidx_t),
    .APPLY_SHIFT (1'b0)
  ) u_gidx_bias (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .stride_i (cfg.w_d0_stride[ITER_W-1:0]),
    .qmode_i  (cfg.qmode),
    .valid_i  (gidx_valid_i),
    .data_i   (gidx_data_i),
    .ready_o  (gidx_ready_o),
    .ready_i  (scales_bias_ready_i),
    .valid_o  (scales_bias_valid_o),
    .bias_o   (scales_bias_o)
  );

  bias_scaler #(
    .idx_t       (row_idx_t),
    .APPLY_SHIFT (1'b1)
  ) u_row_bias (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .stride_i (cfg.w_d0_stride[ITER_W-1:0]),
    .qmode_i  (cfg.qmode),
    .valid_i  (row_valid_i),
    .data_i   (row_data_i),
    .ready_o  (row_ready_o),
    .ready_i  (wq_bias_ready_i),
    .valid_o  (wq_bias_valid_o),
    .bias_o   (wq_bias_o)
  );

endmodule : mem_sched_top

// ==== sim/mem_sched_chk.sv ====
/*
 * Bias scaler checker
 * Output valid stays low in reset, and a stalled output beat holds
 * its valid and data.
 */

module mem_sched_chk
  import mem_sched_pkg::*;
(
  input logic              clk_i,
  input logic              rst_ni,
  input logic              clear_i,
  input logic              out_ready_i,
  input logic              out_valid_i,
  input logic [ADDR_W-1:0] bias_i
);

  int unsigned fail_cnt = 0;

  reset_idle: assert property (@(posedge clk_i) !rst_ni |-> !out_valid_i)
    else begin
      $error("bias output valid during reset");
      fail_cnt++;
    end

  // Clear may drop a stalled beat
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i && !out_ready_i && !clear_i |=> out_valid_i && $stable(bias_i))
    else begin
      $error("bias output changed while stalled");
      fail_cnt++;
    end

endmodule : mem_sched_chk

bind bias_scaler mem_sched_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .clear_i     (clear_i),
  .out_ready_i (ready_i),
  .out_valid_i (valid_o),
  .bias_i      (bias_o)
);

// ==== sim/mem_sched_tb.sv ====
/*
 * Memory scheduler testbench
 * Directed tests for the X tile walk, the descriptors, the start
 * requests, the bias streams and clear, against a reference model.
 */

module mem_sched_tb
  import mem_sched_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned WALK_STEPS   = 18;
  localparam int unsigned BIAS_BEATS   = 12;
  localparam int unsigned BIAS_CYCLES  = 200;
  // Offset of the last memory word inside one beat
  localparam int unsigned STEP_BYTES   = (DATA_W - MEM_DW) / 8;
  localparam int unsigned TEST_CYCLES  = RESET_CYCLES + 2 * (WALK_STEPS + 2) + 70
                                         + 3 * BIAS_CYCLES + 10;

  logic clk_i, rst_ni, clear_i, first_load_i, x_done_i;
  logic [ADDR_W-1:0] x_addr_i, w_addr_i, scales_addr_i, z_addr_i;
  logic [ITER_W-1:0] x_col_iters_i, x_row_iters_i, w_iters_i, w_rows_i;
  logic [ADDR_W-1:0] x_rows_offs_i, x_d1_stride_i, w_d0_stride_i;
  logic [ADDR_W-1:0] w_tot_len_i, z_tot_len_i, z_d0_stride_i;
  logic [ITER_W-1:0] leftover_reads_i, tot_x_reads_i;
  logic dequant_en_i, accumulate_i;
  logic [1:0] qmode_i;
  logic x_ready_i, w_ready_i, y_ready_i, z_ready_i;
  stream_desc_t x_desc_o, w_desc_o, z_desc_o;
  logic x_req_o, w_req_o, y_req_o, z_req_o;
  logic gidx_valid_i, gidx_ready_o, scales_bias_valid_o, scales_bias_ready_i;
  gidx_t gidx_data_i;
  logic row_valid_i, row_ready_o, wq_bias_valid_o, wq_bias_ready_i;
  row_idx_t row_data_i;
  logic [ADDR_W-1:0] scales_bias_o, wq_bias_o;

  int unsigned err_cnt;
  int unsigned assert_cnt;
  // Reference tile position, column innermost
  logic [ITER_W-1:0] ref_col, ref_wpass, ref_row, ref_strobes;

  mem_sched_top #(
    .ARRAY_W (ARRAY_W)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  task automatic report_mismatch(input string test, input logic [ADDR_W-1:0] exp,
                                 input logic [ADDR_W-1:0] act);
    err_cnt++;
    $display("Error: %s expected %h actual %h", test, exp, act);
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("Error: %s", msg);
  endtask

  // Packed weight formats divide the row stride
  function automatic logic [1:0] packed_shift(input logic [1:0] mode);
    if (qmode_e'(mode) == QINT2) return 2'd3;
    if (qmode_e'(mode) == QINT4) return 2'd2;
    return 2'd1;
  endfunction

  task automatic init_inputs();
    rst_ni = 1'b0;
    clear_i = 1'b0;
    first_load_i = 1'b0;
    x_done_i = 1'b0;
    x_addr_i = 32'h1000_0000;
    w_addr_i = 32'h2000_0000;
    scales_addr_i = 32'h2800_0000;
    z_addr_i = 32'h3000_0000;
    x_col_iters_i = 16'd3;
    x_row_iters_i = 16'd3;
    w_iters_i = 16'd2;
    w_rows_i = 16'd16;
    x_rows_offs_i = 32'h400;
    x_d1_stride_i = 32'h80;
    w_d0_stride_i = 32'h140;
    w_tot_len_i = 32'h60;
    z_tot_len_i = 32'h30;
    z_d0_stride_i = 32'h200;
    leftover_reads_i = 16'd2;
    tot_x_reads_i = 16'(WALK_STEPS);
    dequant_en_i = 1'b0;
    qmode_i = 2'd0;
    accumulate_i = 1'b0;
    {x_ready_i, w_ready_i, y_ready_i, z_ready_i} = 4'hf;
    gidx_valid_i = 1'b0;
    gidx_data_i = '0;
    scales_bias_ready_i = 1'b1;
    row_valid_i = 1'b0;
    row_data_i = '0;
    wq_bias_ready_i = 1'b1;
  endtask

  task automatic clear_walker();
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    ref_col = '0;
    ref_wpass = '0;
    ref_row = '0;
    ref_strobes = '0;
  endtask

  task automatic strobe_x();
    x_done_i = 1'b1;
    @(negedge clk_i);
    x_done_i = 1'b0;
    ref_strobes++;
    if (ref_col == x_col_iters_i - 16'd1) begin
      ref_col = '0;
      if (ref_wpass == w_iters_i - 16'd1) begin
        ref_wpass = '0;
        ref_row = (ref_row == x_row_iters_i - 16'd1) ? '0 : ref_row + 16'd1;
      end else begin
        ref_wpass++;
      end
    end else begin
      ref_col++;
    end
  endtask

  // Expects first_load_i low and x_ready_i high
  task automatic check_x_tile(input string test);
    logic [ADDR_W-1:0] exp_base;
    logic [ADDR_W-1:0] exp_len;
    logic              exp_pend;
    exp_base = x_addr_i + x_rows_offs_i * ADDR_W'(ref_row)
               + ADDR_W'(ref_col) * ADDR_W'(STEP_BYTES);
    exp_len = ADDR_W'(ARRAY_W);
    if (ref_row == x_row_iters_i - 16'd1 && leftover_reads_i != '0) begin
      exp_len = ADDR_W'(leftover_reads_i);
    end
    exp_pend = ref_strobes != '0 && ref_strobes != tot_x_reads_i;
    if (x_desc_o.base_addr !== exp_base) report_mismatch({test, " base"}, exp_base,
                                                         x_desc_o.base_addr);
    if (x_desc_o.tot_len !== exp_len) report_mismatch({test, " tot_len"}, exp_len,
                                                      x_desc_o.tot_len);
    if (x_desc_o.d0_len !== ADDR_W'(1)) report_mismatch({test, " d0_len"}, ADDR_W'(1),
                                                        x_desc_o.d0_len);
    if (x_desc_o.d0_stride !== '0) report_mismatch({test, " d0_stride"}, '0,
                                                   x_desc_o.d0_stride);
    if (x_desc_o.d1_len !== ADDR_W'(ARRAY_W)) report_mismatch({test, " d1_len"},
                                                              ADDR_W'(ARRAY_W),
                                                              x_desc_o.d1_len);
    if (x_desc_o.d1_stride !== x_d1_stride_i) report_mismatch({test, " d1_stride"},
                                                              x_d1_stride_i,
                                                              x_desc_o.d1_stride);
    if (x_req_o !== exp_pend) report_mismatch({test, " x_req"}, ADDR_W'(exp_pend),
                                              ADDR_W'(x_req_o));
  endtask

  task automatic test_tile_walk(input string test, input logic [ITER_W-1:0] leftover);
    leftover_reads_i = leftover;
    first_load_i = 1'b0;
    x_ready_i = 1'b1;
    clear_walker();
    check_x_tile(test);
    repeat (WALK_STEPS) begin
      strobe_x();
      check_x_tile(test);
    end
  endtask

  task automatic test_dequant();
    logic [ADDR_W-1:0] exp_base;
    logic [ADDR_W-1:0] exp_stride;
    for (int d = 0; d < 2; d++) begin
      dequant_en_i = (d == 1);
      @(negedge clk_i);
      exp_base = dequant_en_i ? scales_addr_i : w_addr_i;
      exp_stride = dequant_en_i ? '0 : w_d0_stride_i;
      if (w_desc_o.base_addr !== exp_base) report_mismatch("dequant w base", exp_base,
                                                           w_desc_o.base_addr);
      if (w_desc_o.d0_stride !== exp_stride) report_mismatch("dequant w d0_stride",
                                                             exp_stride, w_desc_o.d0_stride);
      if (w_desc_o.tot_len !== w_tot_len_i) report_mismatch("dequant w tot_len",
                                                            w_tot_len_i, w_desc_o.tot_len);
      if (w_desc_o.d0_len !== ADDR_W'(w_rows_i)) report_mismatch("dequant w d0_len",
                                                                 ADDR_W'(w_rows_i),
                                                                 w_desc_o.d0_len);
      if (w_desc_o.d1_len !== ADDR_W'(w_iters_i)) report_mismatch("dequant w d1_len",
                                                                  ADDR_W'(w_iters_i),
                                                                  w_desc_o.d1_len);
      if (w_desc_o.d1_stride !== ADDR_W'(STEP_BYTES)) report_mismatch("dequant w d1_stride",
                                                                      ADDR_W'(STEP_BYTES),
                                                                      w_desc_o.d1_stride);
    end
    if (z_desc_o.base_addr !== z_addr_i) report_mismatch("z base", z_addr_i,
                                                         z_desc_o.base_addr);
    if (z_desc_o.tot_len !== z_tot_len_i) report_mismatch("z tot_len", z_tot_len_i,
                                                          z_desc_o.tot_len);
    if (z_desc_o.d0_len !== ADDR_W'(ARRAY_W)) report_mismatch("z d0_len", ADDR_W'(ARRAY_W),
                                                              z_desc_o.d0_len);
    if (z_desc_o.d0_stride !== z_d0_stride_i) report_mismatch("z d0_stride", z_d0_stride_i,
                                                              z_desc_o.d0_stride);
    if (z_desc_o.d1_len !== ADDR_W'(w_iters_i)) report_mismatch("z d1_len",
                                                                ADDR_W'(w_iters_i),
                                                                z_desc_o.d1_len);
    if (z_desc_o.d1_stride !== ADDR_W'(STEP_BYTES)) report_mismatch("z d1_stride",
                                                                    ADDR_W'(STEP_BYTES),
                                                                    z_desc_o.d1_stride);
    dequant_en_i = 1'b0;
  endtask

  task automatic test_requests();
    logic pend;
    logic exp_x, exp_w, exp_y, exp_z;
    pend = ref_strobes != '0 && ref_strobes != tot_x_reads_i;
    for (int i = 0; i < 64; i++) begin
      {first_load_i, accumulate_i, x_ready_i, w_ready_i, y_ready_i, z_ready_i} = 6'(i);
      @(negedge clk_i);
      exp_x = x_ready_i && (first_load_i || pend);
      exp_w = w_ready_i && first_load_i;
      exp_y = y_ready_i && first_load_i && accumulate_i;
      exp_z = z_ready_i && first_load_i;
      if (x_req_o !== exp_x) report_mismatch("requests x_req", ADDR_W'(exp_x),
                                             ADDR_W'(x_req_o));
      if (w_req_o !== exp_w) report_mismatch("requests w_req", ADDR_W'(exp_w),
                                             ADDR_W'(w_req_o));
      if (y_req_o !== exp_y) report_mismatch("requests y_req", ADDR_W'(exp_y),
                                             ADDR_W'(y_req_o));
      if (z_req_o !== exp_z) report_mismatch("requests z_req", ADDR_W'(exp_z),
                                             ADDR_W'(z_req_o));
    end
    first_load_i = 1'b0;
    accumulate_i = 1'b0;
    {x_ready_i, w_ready_i, y_ready_i, z_ready_i} = 4'hf;
  endtask

  task automatic test_bias(input logic [1:0] mode);
    logic [ADDR_W-1:0] sc_exp[$];
    logic [ADDR_W-1:0] wq_exp[$];
    int unsigned sc_sent, wq_sent, sc_got, wq_got, cycles;
    logic sc_in, wq_in;
    string test;
    test = $sformatf("bias mode %0d", mode);
    {sc_sent, wq_sent, sc_got, wq_got, cycles} = '0;
    {sc_in, wq_in} = 2'b00;
    qmode_i = mode;
    while ((sc_got < BIAS_BEATS || wq_got < BIAS_BEATS) && cycles < BIAS_CYCLES) begin
      // A new offer only once the previous one was taken
      if (!gidx_valid_i || sc_in) begin
        gidx_valid_i = sc_sent < BIAS_BEATS && $urandom_range(1, 0) == 1;
        gidx_data_i = gidx_t'($urandom);
      end
      if (!row_valid_i || wq_in) begin
        row_valid_i = wq_sent < BIAS_BEATS && $urandom_range(1, 0) == 1;
        row_data_i = row_idx_t'($urandom);
      end
      scales_bias_ready_i = $urandom_range(3, 0) != 0;
      wq_bias_ready_i = $urandom_range(2, 0) != 0;
      #1;
      sc_in = gidx_valid_i && gidx_ready_o;
      wq_in = row_valid_i && row_ready_o;
      if (scales_bias_valid_o && scales_bias_ready_i) begin
        if (sc_exp.size() == 0) report_failure({test, ": scales bias without an index"});
        else if (scales_bias_o !== sc_exp[0]) report_mismatch({test, " scales"}, sc_exp[0],
                                                              scales_bias_o);
        if (sc_exp.size() != 0) void'(sc_exp.pop_front());
        sc_got++;
      end
      if (wq_bias_valid_o && wq_bias_ready_i) begin
        if (wq_exp.size() == 0) report_failure({test, ": wq bias without an index"});
        else if (wq_bias_o !== wq_exp[0]) report_mismatch({test, " wq"}, wq_exp[0], wq_bias_o);
        if (wq_exp.size() != 0) void'(wq_exp.pop_front());
        wq_got++;
      end
      if (sc_in) begin
        sc_exp.push_back(ADDR_W'(gidx_data_i) * w_d0_stride_i);
        sc_sent++;
      end
      if (wq_in) begin
        wq_exp.push_back(ADDR_W'(row_data_i) * (w_d0_stride_i >> packed_shift(mode)));
        wq_sent++;
      end
      cycles++;
      @(negedge clk_i);
    end
    if (sc_got != BIAS_BEATS || wq_got != BIAS_BEATS) begin
      report_failure($sformatf("%s: only %0d scales and %0d wq beats came out", test,
                               sc_got, wq_got));
    end
    {gidx_valid_i, row_valid_i} = 2'b00;
    {scales_bias_ready_i, wq_bias_ready_i} = 2'b11;
  endtask

  task automatic test_clear();
    repeat (4) strobe_x();
    gidx_valid_i = 1'b1;
    gidx_data_i = 8'h05;
    row_valid_i = 1'b1;
    row_data_i = 16'h0009;
    {scales_bias_ready_i, wq_bias_ready_i} = 2'b00;
    @(negedge clk_i);
    {gidx_valid_i, row_valid_i} = 2'b00;
    if (scales_bias_valid_o !== 1'b1) report_mismatch("clear scales held", ADDR_W'(1),
                                                      ADDR_W'(scales_bias_valid_o));
    if (wq_bias_valid_o !== 1'b1) report_mismatch("clear wq held", ADDR_W'(1),
                                                  ADDR_W'(wq_bias_valid_o));
    clear_walker();
    check_x_tile("clear");
    if (scales_bias_valid_o !== 1'b0) report_mismatch("clear scales valid", '0,
                                                      ADDR_W'(scales_bias_valid_o));
    if (wq_bias_valid_o !== 1'b0) report_mismatch("clear wq valid", '0,
                                                  ADDR_W'(wq_bias_valid_o));
    {scales_bias_ready_i, wq_bias_ready_i} = 2'b11;
  endtask

  initial begin
    void'($urandom(32'ha4aa));
    err_cnt = 0;
    init_inputs();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    test_tile_walk("tile_walk", 16'd2);
    test_tile_walk("leftover_zero", 16'd0);
    test_dequant();
    test_requests();
    test_bias(2'd0);
    test_bias(2'd1);
    test_bias(2'd2);
    test_clear();
    @(negedge clk_i);
    assert_cnt = dut_i.u_gidx_bias.u_chk.fail_cnt + dut_i.u_row_bias.u_chk.fail_cnt;
    $display("Errors: %0d check, %0d assertion", err_cnt, assert_cnt);
    if (err_cnt == 0 && assert_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : mem_sched_tb

// ==== vlog.f ====
design/mem_sched_pkg.sv
design/x_tile_walker.sv
design/stream_desc_gen.sv
design/bias_scaler.sv
design/mem_sched_top.sv
sim/mem_sched_chk.sv
sim/mem_sched_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f vlog.f --top-module mem_sched_tb \
    -Mdir obj_dir -o mem_sched_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mem_sched_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
